// File: sim.f
src/req_pkg.sv
src/link_pkg.sv
src/req_packer.sv
src/link_tx_fifo.sv
src/link_framer.sv
src/ll_master_top.sv
verification/tb_ll_master_chk.sv
verification/tb_ll_master.sv

// File: verification/tb_ll_master.sv
/*
  Testbench for the write-only link master.
  Clock and reset, LFSR stimulus, request queue and credit
  model, phase checks and the closing error count line.
*/

`default_nettype none

module tb_ll_master;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned FIFO_DEPTH  = 4;
  localparam int unsigned HOLD_REQ    = FIFO_DEPTH + 1;
  localparam int unsigned STALL_CYC   = 16;
  localparam int unsigned N_ORDER     = 60;
  localparam int unsigned N_RET       = 40;
  localparam int unsigned INIT_AMPLE  = 200;
  localparam int unsigned INIT_LIMIT  = 3;

  // Phase lengths in cycles that set the run limit
  localparam int unsigned P1_LEN      = 2 * HOLD_REQ + STALL_CYC;
  localparam int unsigned P2_LEN      = (N_ORDER + 1) * 5 + HOLD_REQ + 4;
  localparam int unsigned P3_LEN      = 4 + 2 * (INIT_LIMIT + HOLD_REQ) + STALL_CYC;
  localparam int unsigned P4_LEN      = (N_RET + HOLD_REQ + 1) * 6 + 4;
  localparam int unsigned TIMEOUT_CYC = 2 * (3 + P1_LEN + P2_LEN + P3_LEN + P4_LEN);

  logic                        clk_wr;
  logic                        rst;
  logic                        tx_online;
  logic [link_pkg::CRED_W-1:0] init_credit;
  req_pkg::req_t               req;
  logic                        req_valid;
  logic                        req_ready;
  link_pkg::tx_word_t          tx_phy;
  link_pkg::rx_word_t          rx_phy;

  logic [15:0]   lfsr_state;
  logic          credit_en;
  logic          prev_online;
  string         test_name;
  req_pkg::req_t model_q [$];
  int unsigned   accepted_cnt;
  int unsigned   sent_cnt;
  int unsigned   epoch_credit;
  int unsigned   epoch_returned;
  int unsigned   epoch_sent;
  int unsigned   value_errs;
  int unsigned   other_errs;
  int unsigned   cycle_cnt;
  int unsigned   mark_sent;

  ll_master_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) UUT (
    .clk_wr      (clk_wr),
    .rst         (rst),
    .tx_online   (tx_online),
    .init_credit (init_credit),
    .req         (req),
    .req_valid   (req_valid),
    .req_ready   (req_ready),
    .tx_phy      (tx_phy),
    .rx_phy      (rx_phy)
  );

  always #4 clk_wr = ~clk_wr;

  ////////////////////////////////////////////////////////////
  // Random source with taps x^16 + x^14 + x^13 + x^11 + 1
  ////////////////////////////////////////////////////////////

  function logic lfsr_step();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  ////////////////////////////////////////////////////////////
  // Reporting
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string what, input logic [79:0] exp,
                                 input logic [79:0] act);
    $display("** Error [%s] %s: expected %h, actual %h", test_name, what, exp, act);
    value_errs++;
  endtask

  task automatic report_failure(input string what);
    $display("Check failed in %s: %s", test_name, what);
    other_errs++;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Inputs change 1 ns after the edge and a credit bit is drawn each cycle
  task automatic next_cycle();
    @(posedge clk_wr);
    #1;
    rx_phy = '0;
    if (credit_en) begin
      rx_phy.credit = lfsr_step();
    end
  endtask

  task automatic present_req();
    req_pkg::req_t r;
    logic [31:0]   v;
    v      = rand_bits(req_pkg::ID_W);
    r.id   = v[req_pkg::ID_W-1:0];
    r.addr = rand_bits(req_pkg::ADDR_W);
    r.data = rand_bits(req_pkg::DATA_W);
    v      = rand_bits(req_pkg::STRB_W);
    r.strb = v[req_pkg::STRB_W-1:0];
    req       = r;
    req_valid = 1'b1;
  endtask

  // Ready seen at the falling edge means transfer at the next rising edge
  task automatic wait_accept();
    logic done;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_wr);
      done = req_ready;
      next_cycle();
    end
    req_valid = 1'b0;
  endtask

  task automatic send_req(input logic gaps);
    int unsigned idle;
    idle = gaps ? rand_bits(2) : 0;
    repeat (idle) next_cycle();
    present_req();
    wait_accept();
  endtask

  task automatic check_stall();
    repeat (STALL_CYC) begin
      @(negedge clk_wr);
      if (req_ready) begin
        report_failure("req_ready high although all buffers should be full");
      end
      next_cycle();
    end
  endtask

  task automatic wait_drain();
    while (model_q.size() != 0) begin
      next_cycle();
    end
    repeat (2) next_cycle();
  endtask

  ////////////////////////////////////////////////////////////
  // Monitor and model sampled mid-cycle
  ////////////////////////////////////////////////////////////

  always @(negedge clk_wr) begin
    req_pkg::req_t exp;
    if (!rst) begin
      if (prev_online) begin
        if (tx_phy.strobe !== 1'b1) begin
          report_mismatch("strobe", 1'b1, tx_phy.strobe);
        end
        if (tx_phy.pad !== '0) begin
          report_mismatch("pad", '0, tx_phy.pad);
        end
        if (tx_phy.pushbit === 1'b0 && tx_phy.payload !== '0) begin
          report_mismatch("idle payload", '0, tx_phy.payload);
        end
      end else if (tx_phy !== '0) begin
        report_mismatch("offline word", '0, tx_phy);
      end
      if (tx_phy.pushbit === 1'b1) begin
        sent_cnt++;
        epoch_sent++;
        if (model_q.size() == 0) begin
          report_failure("word sent with no request pending");
        end else begin
          exp = model_q.pop_front();
          if (tx_phy.payload !== exp) begin
            report_mismatch("payload", exp, tx_phy.payload);
          end
        end
        if (epoch_sent > epoch_credit + epoch_returned) begin
          report_failure("more words sent than credit allowed");
        end
      end
      // Credit model loads while offline and counts returns while online
      if (!tx_online) begin
        epoch_credit   = init_credit;
        epoch_returned = 0;
        epoch_sent     = 0;
      end else if (rx_phy.credit) begin
        epoch_returned++;
      end
      if (req_valid && req_ready) begin
        model_q.push_back(req);
        accepted_cnt++;
      end
      prev_online = tx_online;
    end
  end

  always @(posedge clk_wr) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Result: FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Test phases
  ////////////////////////////////////////////////////////////

  initial begin
    clk_wr       = 1'b0;
    rst          = 1'b1;
    tx_online    = 1'b0;
    init_credit  = '0;
    req          = '0;
    req_valid    = 1'b0;
    rx_phy       = '0;
    lfsr_state   = 16'd85;
    credit_en    = 1'b0;
    prev_online  = 1'b0;
    test_name    = "reset";
    accepted_cnt = 0;
    sent_cnt     = 0;
    value_errs   = 0;
    other_errs   = 0;
    cycle_cnt    = 0;
    repeat (3) @(posedge clk_wr);
    #1;
    rst = 1'b0;

    // Buffers fill offline and nothing is sent
    test_name   = "offline_hold";
    init_credit = INIT_AMPLE;
    repeat (HOLD_REQ) send_req(1'b0);
    present_req();
    check_stall();
    if (accepted_cnt != HOLD_REQ) begin
      report_mismatch("accepted", HOLD_REQ, accepted_cnt);
    end
    if (sent_cnt != 0) begin
      report_mismatch("sent", 0, sent_cnt);
    end

    // Online with ample credit the stalled request goes first
    test_name = "in_order";
    tx_online = 1'b1;
    wait_accept();
    repeat (N_ORDER) send_req(1'b1);
    wait_drain();
    if (sent_cnt != accepted_cnt) begin
      report_mismatch("sent", accepted_cnt, sent_cnt);
    end

    // Reload three credits with none returned
    test_name   = "credit_limit";
    tx_online   = 1'b0;
    init_credit = INIT_LIMIT;
    repeat (2) next_cycle();
    tx_online = 1'b1;
    mark_sent = sent_cnt;
    repeat (INIT_LIMIT + HOLD_REQ) send_req(1'b0);
    present_req();
    check_stall();
    if (sent_cnt - mark_sent != INIT_LIMIT) begin
      report_mismatch("sent", INIT_LIMIT, sent_cnt - mark_sent);
    end

    // Random returns release the held packets
    test_name = "credit_return";
    credit_en = 1'b1;
    wait_accept();
    repeat (N_RET) send_req(1'b1);
    wait_drain();
    credit_en = 1'b0;
    if (sent_cnt != accepted_cnt) begin
      report_mismatch("sent", accepted_cnt, sent_cnt);
    end

    $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/tb_ll_master_chk.sv
/*
  Bound checker for the link master top level.
  Offline words are zero, strobe is set in online words,
  and a waiting user request is held stable.
*/

`default_nettype none

module tb_ll_master_chk (
  input logic               clk_wr,
  input logic               rst,
  input logic               tx_online,
  input req_pkg::req_t      req,
  input logic               req_valid,
  input logic               req_ready,
  input link_pkg::tx_word_t tx_phy
);

  timeunit 1ns;
  timeprecision 100ps;

  ////////////////////////////////////////////////////////////
  // Link side, tx_phy lags tx_online by one cycle
  ////////////////////////////////////////////////////////////

  a_offline_zero : assert property (
    @(posedge clk_wr) disable iff (rst)
    !tx_online |=> (tx_phy == '0)
  ) else $error("tx_phy not zero after an offline cycle");

  a_strobe_on : assert property (
    @(posedge clk_wr) disable iff (rst)
    tx_online |=> tx_phy.strobe
  ) else $error("strobe bit missing after an online cycle");

  ////////////////////////////////////////////////////////////
  // User side
  ////////////////////////////////////////////////////////////

  a_req_stable : assert property (
    @(posedge clk_wr) disable iff (rst)
    (req_valid && !req_ready) |=> $stable(req)
  ) else $error("request changed while waiting for req_ready");

endmodule

bind ll_master_top tb_ll_master_chk u_chk (.*);

`default_nettype wire

// File: src/ll_master_top.sv
/*
  Top level of the write-only link master.
  Request packer, transmit FIFO and link framer in a chain
  from the user handshake to the 80-bit PHY word.
*/

`default_nettype none

module ll_master_top #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                        clk_wr,
  input  logic                        rst,

  // Link control
  input  logic                        tx_online,
  input  logic [link_pkg::CRED_W-1:0] init_credit,

  // User request
  input  req_pkg::req_t               req,
  input  logic                        req_valid,
  output logic                        req_ready,

  // PHY interconnect
  output link_pkg::tx_word_t          tx_phy,
  input  link_pkg::rx_word_t          rx_phy
);

  ////////////////////////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////////////////////////

  req_pkg::req_t pkt;
  logic          pkt_valid;
  logic          pkt_ready;

  req_pkg::req_t head;
  logic          head_valid;
  logic          head_pop;

  ////////////////////////////////////////////////////////////
  // Producer, buffer, consumer
  ////////////////////////////////////////////////////////////

  req_packer u_req_packer (
    .clk_wr    (clk_wr),
    .rst       (rst),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .pkt       (pkt),
    .pkt_valid (pkt_valid),
    .pkt_ready (pkt_ready)
  );

  link_tx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_link_tx_fifo (
    .clk_wr     (clk_wr),
    .rst        (rst),
    .pkt        (pkt),
    .pkt_valid  (pkt_valid),
    .pkt_ready  (pkt_ready),
    .head       (head),
    .head_valid (head_valid),
    .head_pop   (head_pop)
  );

  link_framer u_link_framer (
    .clk_wr      (clk_wr),
    .rst         (rst),
    .tx_online   (tx_online),
    .init_credit (init_credit),
    .rx_phy      (rx_phy),
    .head        (head),
    .head_valid  (head_valid),
    .head_pop    (head_pop),
    .tx_phy      (tx_phy)
  );

endmodule

`default_nettype wire

// File: src/link_framer.sv
/*
  Link framer, the consumer stage of the link master.
  Transmit credit counter, pop decision and the registered
  outgoing PHY word with strobe, pushbit and payload.
*/

`default_nettype none

module link_framer (
  input  logic                        clk_wr,
  input  logic                        rst,

  // Link control
  input  logic                        tx_online,
  input  logic [link_pkg::CRED_W-1:0] init_credit,
  input  link_pkg::rx_word_t          rx_phy,

  // FIFO head
  input  req_pkg::req_t               head,
  input  logic                        head_valid,
  output logic                        head_pop,

  // PHY output
  output link_pkg::tx_word_t          tx_phy
);

  logic [link_pkg::CRED_W-1:0] tx_credit;
  logic [link_pkg::CRED_W-1:0] cred_add;
  logic [link_pkg::CRED_W-1:0] cred_sub;
  logic                        have_credit;

  ////////////////////////////////////////////////////////////
  // Pop decision
  ////////////////////////////////////////////////////////////

  assign have_credit = (tx_credit != '0);

  // Only online, with a packet waiting and at least one credit
  assign head_pop = tx_online & head_valid & have_credit;

  ////////////////////////////////////////////////////////////
  // Transmit credit
  ////////////////////////////////////////////////////////////

  // One unit returned or spent per cycle
  assign cred_add = {{(link_pkg::CRED_W-1){1'b0}}, rx_phy.credit};
  assign cred_sub = {{(link_pkg::CRED_W-1){1'b0}}, head_pop};

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_credit <= '0;
    end else if (!tx_online) begin
      // Offline the far end grants its starting credit
      tx_credit <= init_credit;
    end else begin
      tx_credit <= tx_credit + cred_add - cred_sub;
    end
  end

  ////////////////////////////////////////////////////////////
  // Outgoing word
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_phy <= '0;
    end else if (!tx_online) begin
      tx_phy <= '0;
    end else begin
      tx_phy.pad     <= '0;
      tx_phy.strobe  <= link_pkg::STB_ON;
      tx_phy.pushbit <= head_pop;
      // Idle words carry a zero payload
      if (head_pop) begin
        tx_phy.payload <= head;
      end else begin
        tx_phy.payload <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// File: src/link_tx_fifo.sv
/*
  Transmit FIFO of the link master.
  Circular buffer of packets between the packer and the framer.
  Pointers carry an extra wrap bit to tell full from empty.
*/

`default_nettype none

module link_tx_fifo #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic          clk_wr,
  input  logic          rst,

  // Write side
  input  req_pkg::req_t pkt,
  input  logic          pkt_valid,
  output logic          pkt_ready,

  // Read side
  output req_pkg::req_t head,
  output logic          head_valid,
  input  logic          head_pop
);

  localparam int unsigned ADDR_W = $clog2(FIFO_DEPTH);

  req_pkg::req_t mem [FIFO_DEPTH];

  // Address bits plus wrap bit on top
  logic [ADDR_W:0] wr_ptr;
  logic [ADDR_W:0] rd_ptr;

  logic full;
  logic empty;
  logic wr_en;
  logic rd_en;

  ////////////////////////////////////////////////////////////
  // Status
  ////////////////////////////////////////////////////////////

  // Same address, opposite lap means full
  assign full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);
  assign empty = (wr_ptr == rd_ptr);

  // A pop frees the slot that a full FIFO writes into
  assign pkt_ready  = ~full | head_pop;
  assign head_valid = ~empty;

  assign wr_en = pkt_valid & pkt_ready;
  assign rd_en = head_pop & ~empty;

  ////////////////////////////////////////////////////////////
  // Pointers and storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_ptr[ADDR_W-1:0]] <= pkt;
    end
  end

  // Head read is combinational from the storage array
  assign head = mem[rd_ptr[ADDR_W-1:0]];

endmodule

`default_nettype wire

// File: src/req_packer.sv
/*
  Request packer, the producer stage of the link master.
  One-entry packet register between the user handshake and
  the transmit FIFO, with pass-through ready for full rate.
*/

`default_nettype none

module req_packer (
  input  logic          clk_wr,
  input  logic          rst,

  // User side
  input  req_pkg::req_t req,
  input  logic          req_valid,
  output logic          req_ready,

  // Towards the transmit FIFO
  output req_pkg::req_t pkt,
  output logic          pkt_valid,
  input  logic          pkt_ready
);

  // Set one cycle after reset release, user side stays closed until then
  logic accept_en;
  logic req_fire;

  ////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////

  // Register empty, or its packet leaves in this same cycle
  assign req_ready = accept_en & (~pkt_valid | pkt_ready);
  assign req_fire  = req_valid & req_ready;

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      accept_en <= 1'b0;
      pkt_valid <= 1'b0;
    end else begin
      accept_en <= 1'b1;
      if (req_ready) begin
        pkt_valid <= req_valid;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Packet register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_wr) begin
    if (req_fire) begin
      pkt <= req;
    end
  end

endmodule

`default_nettype wire

// File: src/link_pkg.sv
/*
  PHY side definitions for the link master.
  Word width, credit counter width, padding and strobe value,
  plus the transmit and receive PHY word layouts.
*/

`default_nettype none

package link_pkg;

  ////////////////////////////////////////////////////////////
  // Link constants
  ////////////////////////////////////////////////////////////

  localparam int unsigned PHY_W  = 80;
  localparam int unsigned CRED_W = 8;

  // Spare bits above the payload in a transmit word
  localparam int unsigned PAD_W  = PHY_W - 2 - $bits(req_pkg::req_t);

  // Strobe is persistent, sent high in every online word
  localparam logic STB_ON = 1'b1;

  ////////////////////////////////////////////////////////////
  // PHY words, strobe and credit sit in bit 0
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [PAD_W-1:0] pad;
    req_pkg::req_t    payload;
    logic             pushbit;
    logic             strobe;
  } tx_word_t;

  typedef struct packed {
    logic [PHY_W-2:0] unused;
    logic             credit;
  } rx_word_t;

endpackage

`default_nettype wire

// File: src/req_pkg.sv
/*
  User request definitions for the link master.
  Field widths of the write request and the packed request
  struct, which also serves as the packet payload.
*/

`default_nettype none

package req_pkg;

  ////////////////////////////////////////////////////////////
  // Field widths
  ////////////////////////////////////////////////////////////

  // Request id, small tag returned by nobody here
  localparam int unsigned ID_W   = 4;
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  // One strobe bit per data byte
  localparam int unsigned STRB_W = DATA_W / 8;

  ////////////////////////////////////////////////////////////
  // Write request, 72 bits
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } req_t;

endpackage

`default_nettype wire
